//--- files.f
logic/ooo_pkg.sv
logic/dispatch_stage.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
testbench/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - logic/ooo_pkg.sv
      - logic/dispatch_stage.sv
      - logic/reservation_station.sv
      - logic/alu_unit.sv
      - logic/reorder_buffer.sv
      - logic/ooo_core.sv
  - target: simulation
    files:
      - testbench/tb_ooo_core.sv

//--- testbench/tb_ooo_core.sv
// testbench for the out-of-order core
// directed and random ALU streams, a model register file computes
// each expected commit at dispatch, commits are checked in order

`timescale 1ns/10ps

module tb_ooo_core import ooo_pkg::*;;

    localparam int    MUL_CYCLES  = 4;
    localparam int    NUM_RANDOM  = 300;
    localparam int    TOTAL_INSTS = 35 + NUM_RANDOM;
    localparam real   PERIOD_NS   = 40.0;
    localparam real   TIMEOUT_NS  = TOTAL_INSTS * (MUL_CYCLES + 4) * PERIOD_NS + 4000.0;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clock;
    logic        reset;
    logic        inst_valid;
    alu_func_e   inst_func;
    reg_idx_t    inst_dest;
    reg_idx_t    inst_src1;
    reg_idx_t    inst_src2;
    opb_select_e inst_opb_select;
    xlen_t       inst_imm;
    logic        dispatch_ok;
    logic        commit_valid;
    reg_idx_t    commit_dest;
    xlen_t       commit_data;

    // model state and scoreboard
    xlen_t       model_regs [32];
    reg_idx_t    exp_dest [$];
    xlen_t       exp_data [$];
    string       test_name;
    int          accept_count;
    int          commit_count;
    logic        saw_stall;
    logic [31:0] lfsr;

    ooo_core dut_i (
        .clock(clock),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst_func(inst_func),
        .inst_dest(inst_dest),
        .inst_src1(inst_src1),
        .inst_src2(inst_src2),
        .inst_opb_select(inst_opb_select),
        .inst_imm(inst_imm),
        .dispatch_ok(dispatch_ok),
        .commit_valid(commit_valid),
        .commit_dest(commit_dest),
        .commit_data(commit_data)
    );

    always #(PERIOD_NS / 2) clock = !clock;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // expected ALU result
    function automatic xlen_t alu_result(input alu_func_e func, input xlen_t a, input xlen_t b);
        case (func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return a * b;
        endcase
    endfunction

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return bits;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // drive on the falling edge, hold until dispatch_ok, then update the model
    task automatic send_inst(input alu_func_e func, input reg_idx_t dest, input reg_idx_t src1,
                             input reg_idx_t src2, input opb_select_e sel, input xlen_t imm);
        xlen_t opa;
        xlen_t opb;
        xlen_t result;
        @(negedge clock);
        inst_valid      = 1'b1;
        inst_func       = func;
        inst_dest       = dest;
        inst_src1       = src1;
        inst_src2       = src2;
        inst_opb_select = sel;
        inst_imm        = imm;
        while (!dispatch_ok) begin
            saw_stall = 1'b1;
            @(negedge clock);
        end
        opa    = (src1 == '0) ? '0 : model_regs[src1];
        opb    = (sel == OPB_IS_IMM) ? imm : ((src2 == '0) ? '0 : model_regs[src2]);
        result = alu_result(func, opa, opb);
        if (dest != '0) begin
            model_regs[dest] = result;
        end
        exp_dest.push_back(dest);
        exp_data.push_back(result);
        accept_count++;
    endtask

    // stop sending and wait for every pending commit
    task automatic drain_pipeline();
        @(negedge clock);
        inst_valid = 1'b0;
        while (exp_data.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic random_burst();
        alu_func_e   func;
        opb_select_e sel;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            // roughly half muls to keep the ALU busy
            func = next_bits(1) ? ALU_MUL : alu_func_e'(next_bits(3));
            sel  = opb_select_e'(next_bits(1));
            send_inst(func, reg_idx_t'(next_bits(3)), reg_idx_t'(next_bits(3)),
                      reg_idx_t'(next_bits(3)), sel, next_bits(32));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // commit checker
    ////////////////////////////////////////////////////////////////////////////

    // commit outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (exp_data.size() == 0) begin
                $display("Commit seen with no instruction pending in %s", test_name);
                $display("Regression failed");
                $fatal(1);
            end else begin
                check_value("commit_dest", 32'(exp_dest.pop_front()), 32'(commit_dest));
                check_value("commit_data", exp_data.pop_front(), commit_data);
                commit_count++;
            end
        end
    end

    // watchdog also reports the instructions still waiting for commit
    initial begin
        #(TIMEOUT_NS);
        $display("Run did not finish in time during %s", test_name);
        $display("%0d of %0d accepted instructions committed, %0d still pending",
                 commit_count, accept_count, exp_data.size());
        $display("Regression failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        inst_valid      = 1'b0;
        inst_func       = ALU_ADD;
        inst_dest       = '0;
        inst_src1       = '0;
        inst_src2       = '0;
        inst_opb_select = OPB_IS_RS2;
        inst_imm        = '0;
        model_regs      = '{default: '0};
        accept_count    = 0;
        commit_count    = 0;
        saw_stall       = 1'b0;
        lfsr            = 32'h1eaf_e7ae;
        test_name       = "reset";
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // idle after reset
        @(negedge clock);
        check_value("commit_valid", 32'd0, 32'(commit_valid));
        check_value("dispatch_ok", 32'd1, 32'(dispatch_ok));

        test_name = "independent";
        send_inst(ALU_ADD, 5'd1, 5'd0, 5'd0, OPB_IS_IMM, 32'h1234_5678);
        send_inst(ALU_ADD, 5'd2, 5'd0, 5'd0, OPB_IS_IMM, 32'h0f0f_00e5);
        drain_pipeline();
        // register forms then immediate forms, every single-cycle op
        for (int f = 0; f < 7; f++) begin
            send_inst(alu_func_e'(f), reg_idx_t'(4 + f), 5'd1, 5'd2, OPB_IS_RS2, 32'hdead_beef);
        end
        for (int f = 0; f < 7; f++) begin
            send_inst(alu_func_e'(f), reg_idx_t'(11 + f), 5'd2, 5'd0, OPB_IS_IMM,
                      32'h8765_4321 ^ 32'(f * 7));
        end
        drain_pipeline();

        test_name = "dependency_chain";
        // back to back through the CDB and the buffer
        send_inst(ALU_ADD, 5'd1, 5'd0, 5'd0, OPB_IS_IMM, 32'd3);
        send_inst(ALU_ADD, 5'd1, 5'd1, 5'd1, OPB_IS_RS2, 32'd0);
        send_inst(ALU_SUB, 5'd2, 5'd1, 5'd0, OPB_IS_IMM, 32'd1);
        send_inst(ALU_XOR, 5'd3, 5'd2, 5'd1, OPB_IS_RS2, 32'd0);
        send_inst(ALU_SLL, 5'd4, 5'd3, 5'd0, OPB_IS_IMM, 32'd2);
        send_inst(ALU_MUL, 5'd9, 5'd4, 5'd3, OPB_IS_RS2, 32'd0);
        send_inst(ALU_ADD, 5'd10, 5'd9, 5'd0, OPB_IS_IMM, 32'd100);
        drain_pipeline();
        // sources from the register file after retire
        send_inst(ALU_ADD, 5'd5, 5'd4, 5'd3, OPB_IS_RS2, 32'd0);
        send_inst(ALU_OR, 5'd11, 5'd10, 5'd5, OPB_IS_RS2, 32'd0);
        // r0 writes commit, reads stay zero
        send_inst(ALU_ADD, 5'd0, 5'd0, 5'd0, OPB_IS_IMM, 32'h55);
        send_inst(ALU_ADD, 5'd6, 5'd0, 5'd0, OPB_IS_RS2, 32'd0);
        send_inst(ALU_ADD, 5'd0, 5'd1, 5'd0, OPB_IS_IMM, 32'h77);
        send_inst(ALU_ADD, 5'd7, 5'd0, 5'd1, OPB_IS_RS2, 32'd0);
        send_inst(ALU_OR, 5'd8, 5'd0, 5'd0, OPB_IS_IMM, 32'd9);
        drain_pipeline();

        test_name = "mul_then_independent";
        send_inst(ALU_MUL, 5'd12, 5'd1, 5'd2, OPB_IS_RS2, 32'd0);
        send_inst(ALU_ADD, 5'd13, 5'd3, 5'd0, OPB_IS_IMM, 32'h1000);
        send_inst(ALU_XOR, 5'd14, 5'd4, 5'd5, OPB_IS_RS2, 32'd0);
        send_inst(ALU_SRL, 5'd15, 5'd10, 5'd0, OPB_IS_IMM, 32'd3);
        send_inst(ALU_SUB, 5'd16, 5'd12, 5'd13, OPB_IS_RS2, 32'd0);
        drain_pipeline();

        test_name = "random_burst";
        saw_stall = 1'b0;
        random_burst();
        drain_pipeline();
        check_value("dispatch stall seen", 32'd1, 32'(saw_stall));

        // quiet cycles catch extra commits
        repeat (2 * MUL_CYCLES + 4) @(negedge clock);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- logic/ooo_core.sv
// out-of-order integer core, dispatch to retire
// dispatch, reservation station, ALU and reorder buffer around one CDB

`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; #(
    parameter int ROB_DEPTH  = 8,
    parameter int RS_DEPTH   = 4,
    parameter int MUL_CYCLES = 4,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_valid,
    input  alu_func_e   inst_func,
    input  reg_idx_t    inst_dest,
    input  reg_idx_t    inst_src1,
    input  reg_idx_t    inst_src2,
    input  opb_select_e inst_opb_select,
    input  xlen_t       inst_imm,
    output logic        dispatch_ok,
    output logic        commit_valid,
    output reg_idx_t    commit_dest,
    output xlen_t       commit_data
);

    ////////////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////////////

    // dispatch and reorder buffer
    logic             rob_alloc;
    reg_idx_t         rob_alloc_dest;
    logic [TAG_W-1:0] rob_alloc_tag;
    logic             rob_full;
    logic [TAG_W-1:0] rob_read_tag1;
    logic [TAG_W-1:0] rob_read_tag2;
    logic             rob_read_done1;
    logic             rob_read_done2;
    xlen_t            rob_read_value1;
    xlen_t            rob_read_value2;

    // dispatch and station
    logic             rs_free;
    logic             rs_load;
    alu_func_e        rs_func;
    xlen_t            rs_value1;
    xlen_t            rs_value2;
    logic [TAG_W-1:0] rs_tag1;
    logic [TAG_W-1:0] rs_tag2;
    logic             rs_ready1;
    logic             rs_ready2;
    logic [TAG_W-1:0] rs_dest_tag;

    // issue, CDB and retire
    logic             issue_valid;
    alu_func_e        issue_func;
    xlen_t            issue_opa;
    xlen_t            issue_opb;
    logic [TAG_W-1:0] issue_tag;
    logic             fu_ready;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    xlen_t            cdb_value;
    logic [TAG_W-1:0] retire_tag;

    dispatch_stage #(
        .ROB_DEPTH(ROB_DEPTH)
    ) dispatch_i (
        .clock(clock),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst_func(inst_func),
        .inst_dest(inst_dest),
        .inst_src1(inst_src1),
        .inst_src2(inst_src2),
        .inst_opb_select(inst_opb_select),
        .inst_imm(inst_imm),
        .dispatch_ok(dispatch_ok),
        .rob_alloc(rob_alloc),
        .rob_alloc_dest(rob_alloc_dest),
        .rob_alloc_tag(rob_alloc_tag),
        .rob_full(rob_full),
        .rob_read_tag1(rob_read_tag1),
        .rob_read_tag2(rob_read_tag2),
        .rob_read_done1(rob_read_done1),
        .rob_read_done2(rob_read_done2),
        .rob_read_value1(rob_read_value1),
        .rob_read_value2(rob_read_value2),
        .rs_free(rs_free),
        .rs_load(rs_load),
        .rs_func(rs_func),
        .rs_value1(rs_value1),
        .rs_value2(rs_value2),
        .rs_tag1(rs_tag1),
        .rs_tag2(rs_tag2),
        .rs_ready1(rs_ready1),
        .rs_ready2(rs_ready2),
        .rs_dest_tag(rs_dest_tag),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value),
        .retire_valid(commit_valid),
        .retire_dest(commit_dest),
        .retire_tag(retire_tag),
        .retire_value(commit_data)
    );

    reservation_station #(
        .ROB_DEPTH(ROB_DEPTH),
        .RS_DEPTH(RS_DEPTH)
    ) rs_i (
        .clock(clock),
        .reset(reset),
        .load(rs_load),
        .load_func(rs_func),
        .load_value1(rs_value1),
        .load_value2(rs_value2),
        .load_tag1(rs_tag1),
        .load_tag2(rs_tag2),
        .load_ready1(rs_ready1),
        .load_ready2(rs_ready2),
        .load_dest_tag(rs_dest_tag),
        .rs_free(rs_free),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value),
        .fu_ready(fu_ready),
        .issue_valid(issue_valid),
        .issue_func(issue_func),
        .issue_opa(issue_opa),
        .issue_opb(issue_opb),
        .issue_tag(issue_tag)
    );

    alu_unit #(
        .ROB_DEPTH(ROB_DEPTH),
        .MUL_CYCLES(MUL_CYCLES)
    ) alu_i (
        .clock(clock),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_func(issue_func),
        .issue_opa(issue_opa),
        .issue_opb(issue_opb),
        .issue_tag(issue_tag),
        .fu_ready(fu_ready),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value)
    );

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob_i (
        .clock(clock),
        .reset(reset),
        .alloc(rob_alloc),
        .alloc_dest(rob_alloc_dest),
        .alloc_tag(rob_alloc_tag),
        .full(rob_full),
        .read_tag1(rob_read_tag1),
        .read_tag2(rob_read_tag2),
        .read_done1(rob_read_done1),
        .read_done2(rob_read_done2),
        .read_value1(rob_read_value1),
        .read_value2(rob_read_value2),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value),
        .retire_valid(commit_valid),
        .retire_dest(commit_dest),
        .retire_tag(retire_tag),
        .retire_value(commit_data)
    );

endmodule

//--- logic/reorder_buffer.sv
// reorder buffer
// circular buffer of in-flight results, tag allocation at dispatch,
// CDB capture, value forwarding to dispatch and in-order retire

`timescale 1ns/10ps

module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clock,
    input  logic             reset,
    // allocation at dispatch
    input  logic             alloc,
    input  reg_idx_t         alloc_dest,
    output logic [TAG_W-1:0] alloc_tag,
    output logic             full,
    // operand read ports
    input  logic [TAG_W-1:0] read_tag1,
    input  logic [TAG_W-1:0] read_tag2,
    output logic             read_done1,
    output logic             read_done2,
    output xlen_t            read_value1,
    output xlen_t            read_value2,
    // common data bus
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  xlen_t            cdb_value,
    // retire
    output logic             retire_valid,
    output reg_idx_t         retire_dest,
    output logic [TAG_W-1:0] retire_tag,
    output xlen_t            retire_value
);

    logic [ROB_DEPTH-1:0] done;
    reg_idx_t             dest [ROB_DEPTH];
    xlen_t                value [ROB_DEPTH];
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    // one bit wider than the pointers to tell full from empty
    logic [TAG_W:0]       count;

    assign alloc_tag = tail;
    assign full      = (count == (TAG_W + 1)'(ROB_DEPTH));

    assign read_done1  = done[read_tag1];
    assign read_done2  = done[read_tag2];
    assign read_value1 = value[read_tag1];
    assign read_value2 = value[read_tag2];

    ////////////////////////////////////////////////////////////////////////////
    // retire from the head
    ////////////////////////////////////////////////////////////////////////////

    assign retire_valid = (count != '0) && done[head];
    assign retire_dest  = dest[head];
    assign retire_tag   = head;
    assign retire_value = value[head];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            // tail slot is never the one the bus is writing
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (TAG_W + 1)'(alloc) - (TAG_W + 1)'(retire_valid);
        end
    end

    // destination and result payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest[tail] <= alloc_dest;
        end
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_value;
        end
    end

endmodule

//--- logic/alu_unit.sv
// integer ALU with a multi-cycle multiply
// single-cycle results and the product go out on the CDB from one register

`timescale 1ns/10ps

module alu_unit import ooo_pkg::*; #(
    parameter int ROB_DEPTH  = 8,
    parameter int MUL_CYCLES = 4,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int CNT_W = $clog2(MUL_CYCLES)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             issue_valid,
    input  alu_func_e        issue_func,
    input  xlen_t            issue_opa,
    input  xlen_t            issue_opb,
    input  logic [TAG_W-1:0] issue_tag,
    output logic             fu_ready,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output xlen_t            cdb_value
);

    typedef enum logic {
        ALU_IDLE     = 1'b0,
        ALU_MUL_BUSY = 1'b1
    } alu_state_e;

    alu_state_e       state;
    logic [CNT_W-1:0] mul_count;
    xlen_t            mul_a;
    xlen_t            mul_b;
    logic [TAG_W-1:0] mul_tag;
    xlen_t            result;
    logic             single_fire;
    logic             mul_done;

    always_comb begin
        case (issue_func)
            ALU_ADD: result = issue_opa + issue_opb;
            ALU_SUB: result = issue_opa - issue_opb;
            ALU_AND: result = issue_opa & issue_opb;
            ALU_OR:  result = issue_opa | issue_opb;
            ALU_XOR: result = issue_opa ^ issue_opb;
            ALU_SLL: result = issue_opa << issue_opb[4:0];
            ALU_SRL: result = issue_opa >> issue_opb[4:0];
            default: result = '0;
        endcase
    end

    assign fu_ready    = (state == ALU_IDLE);
    assign single_fire = issue_valid && (issue_func != ALU_MUL);
    assign mul_done    = (state == ALU_MUL_BUSY) && (mul_count == '0);

    // multiply sequencing, the last busy cycle writes the product
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= ALU_IDLE;
            mul_count <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= single_fire || mul_done;
            if (state == ALU_IDLE) begin
                if (issue_valid && (issue_func == ALU_MUL)) begin
                    state     <= ALU_MUL_BUSY;
                    mul_count <= CNT_W'(MUL_CYCLES - 2);
                end
            end else if (mul_done) begin
                state <= ALU_IDLE;
            end else begin
                mul_count <= mul_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid && (issue_func == ALU_MUL)) begin
            mul_a   <= issue_opa;
            mul_b   <= issue_opb;
            mul_tag <= issue_tag;
        end
        if (single_fire) begin
            cdb_tag   <= issue_tag;
            cdb_value <= result;
        end else if (mul_done) begin
            cdb_tag   <= mul_tag;
            cdb_value <= mul_a * mul_b;
        end
    end

endmodule

//--- logic/reservation_station.sv
// reservation station for the single ALU
// holds waiting instructions, captures operands from the CDB and issues
// the oldest entry with both operands ready

`timescale 1ns/10ps

module reservation_station import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int RS_DEPTH  = 4,
    localparam int TAG_W = $clog2(ROB_DEPTH),
    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1
) (
    input  logic             clock,
    input  logic             reset,
    // load from dispatch
    input  logic             load,
    input  alu_func_e        load_func,
    input  xlen_t            load_value1,
    input  xlen_t            load_value2,
    input  logic [TAG_W-1:0] load_tag1,
    input  logic [TAG_W-1:0] load_tag2,
    input  logic             load_ready1,
    input  logic             load_ready2,
    input  logic [TAG_W-1:0] load_dest_tag,
    output logic             rs_free,
    // common data bus
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  xlen_t            cdb_value,
    // issue to the ALU
    input  logic             fu_ready,
    output logic             issue_valid,
    output alu_func_e        issue_func,
    output xlen_t            issue_opa,
    output xlen_t            issue_opb,
    output logic [TAG_W-1:0] issue_tag
);

    logic [RS_DEPTH-1:0] valid;
    logic [RS_DEPTH-1:0] ready1;
    logic [RS_DEPTH-1:0] ready2;
    // age counts the younger valid entries, so the oldest has the largest
    logic [IDX_W-1:0]    age [RS_DEPTH];
    alu_func_e           func [RS_DEPTH];
    xlen_t               value1 [RS_DEPTH];
    xlen_t               value2 [RS_DEPTH];
    logic [TAG_W-1:0]    tag1 [RS_DEPTH];
    logic [TAG_W-1:0]    tag2 [RS_DEPTH];
    logic [TAG_W-1:0]    dest_tag [RS_DEPTH];

    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    issue_idx;
    logic                found;
    logic                issue_fire;

    // lowest free slot
    always_comb begin
        rs_free  = 1'b0;
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                rs_free  = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    // oldest ready entry
    always_comb begin
        found     = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && ready1[i] && ready2[i] && (!found || (age[i] > age[issue_idx]))) begin
                found     = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign issue_fire  = found && fu_ready;
    assign issue_valid = issue_fire;
    assign issue_func  = func[issue_idx];
    assign issue_opa   = value1[issue_idx];
    assign issue_opb   = value2[issue_idx];
    assign issue_tag   = dest_tag[issue_idx];

    ////////////////////////////////////////////////////////////////////////////
    // entry control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid  <= '0;
            ready1 <= '0;
            ready2 <= '0;
            age    <= '{default: '0};
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_fire && (issue_idx == IDX_W'(i))) begin
                    valid[i] <= 1'b0;
                end else if (valid[i]) begin
                    // one more younger on load, one less if a younger issues
                    age[i] <= age[i] + IDX_W'(load)
                              - IDX_W'(issue_fire && (age[i] > age[issue_idx]));
                    if (cdb_valid && !ready1[i] && (tag1[i] == cdb_tag)) begin
                        ready1[i] <= 1'b1;
                    end
                    if (cdb_valid && !ready2[i] && (tag2[i] == cdb_tag)) begin
                        ready2[i] <= 1'b1;
                    end
                end else if (load && (free_idx == IDX_W'(i))) begin
                    valid[i]  <= 1'b1;
                    age[i]    <= '0;
                    ready1[i] <= load_ready1;
                    ready2[i] <= load_ready2;
                end
            end
        end
    end

    // entry payload and operand capture
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (load && !valid[i] && (free_idx == IDX_W'(i))) begin
                func[i]     <= load_func;
                value1[i]   <= load_value1;
                value2[i]   <= load_value2;
                tag1[i]     <= load_tag1;
                tag2[i]     <= load_tag2;
                dest_tag[i] <= load_dest_tag;
            end else if (valid[i] && cdb_valid) begin
                if (!ready1[i] && (tag1[i] == cdb_tag)) begin
                    value1[i] <= cdb_value;
                end
                if (!ready2[i] && (tag2[i] == cdb_tag)) begin
                    value2[i] <= cdb_value;
                end
            end
        end
    end

endmodule

//--- logic/dispatch_stage.sv
// dispatch stage of the out-of-order core
// register file and map table, operand lookup from CDB, reorder buffer
// or register file, and dispatch gating on buffer and station space

`timescale 1ns/10ps

module dispatch_stage import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clock,
    input  logic             reset,
    // decoded instruction
    input  logic             inst_valid,
    input  alu_func_e        inst_func,
    input  reg_idx_t         inst_dest,
    input  reg_idx_t         inst_src1,
    input  reg_idx_t         inst_src2,
    input  opb_select_e      inst_opb_select,
    input  xlen_t            inst_imm,
    output logic             dispatch_ok,
    // reorder buffer allocation and read ports
    output logic             rob_alloc,
    output reg_idx_t         rob_alloc_dest,
    input  logic [TAG_W-1:0] rob_alloc_tag,
    input  logic             rob_full,
    output logic [TAG_W-1:0] rob_read_tag1,
    output logic [TAG_W-1:0] rob_read_tag2,
    input  logic             rob_read_done1,
    input  logic             rob_read_done2,
    input  xlen_t            rob_read_value1,
    input  xlen_t            rob_read_value2,
    // reservation station load
    input  logic             rs_free,
    output logic             rs_load,
    output alu_func_e        rs_func,
    output xlen_t            rs_value1,
    output xlen_t            rs_value2,
    output logic [TAG_W-1:0] rs_tag1,
    output logic [TAG_W-1:0] rs_tag2,
    output logic             rs_ready1,
    output logic             rs_ready2,
    output logic [TAG_W-1:0] rs_dest_tag,
    // common data bus
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  xlen_t            cdb_value,
    // in-order retire
    input  logic             retire_valid,
    input  reg_idx_t         retire_dest,
    input  logic [TAG_W-1:0] retire_tag,
    input  xlen_t            retire_value
);

    xlen_t            regfile [32];
    logic [31:0]      map_busy;
    logic [TAG_W-1:0] map_tag [32];

    // per operand lookup, index 0 is operand a and 1 is operand b
    reg_idx_t         src [2];
    logic             op_const [2];
    xlen_t            const_value [2];
    logic             rd_done [2];
    xlen_t            rd_value [2];
    logic [TAG_W-1:0] op_tag [2];
    xlen_t            op_value [2];
    logic             op_ready [2];
    logic             fire;

    assign dispatch_ok = !rob_full && rs_free;
    assign fire        = inst_valid && dispatch_ok;

    assign src[0]         = inst_src1;
    assign src[1]         = inst_src2;
    assign op_const[0]    = (inst_src1 == '0);
    assign op_const[1]    = (inst_opb_select == OPB_IS_IMM) || (inst_src2 == '0);
    assign const_value[0] = '0;
    assign const_value[1] = (inst_opb_select == OPB_IS_IMM) ? inst_imm : '0;
    assign rd_done[0]     = rob_read_done1;
    assign rd_done[1]     = rob_read_done2;
    assign rd_value[0]    = rob_read_value1;
    assign rd_value[1]    = rob_read_value2;

    ////////////////////////////////////////////////////////////////////////////
    // operand resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            op_tag[k]   = map_tag[src[k]];
            op_ready[k] = 1'b1;
            if (op_const[k]) begin
                op_value[k] = const_value[k];
            end else if (map_busy[src[k]]) begin
                // producer still in flight, try the bus then the buffer
                if (cdb_valid && (cdb_tag == op_tag[k])) begin
                    op_value[k] = cdb_value;
                end else if (rd_done[k]) begin
                    op_value[k] = rd_value[k];
                end else begin
                    op_value[k] = '0;
                    op_ready[k] = 1'b0;
                end
            end else begin
                op_value[k] = regfile[src[k]];
            end
        end
    end

    assign rob_read_tag1  = map_tag[inst_src1];
    assign rob_read_tag2  = map_tag[inst_src2];
    assign rob_alloc      = fire;
    assign rob_alloc_dest = inst_dest;

    assign rs_load     = fire;
    assign rs_func     = inst_func;
    assign rs_value1   = op_value[0];
    assign rs_value2   = op_value[1];
    assign rs_tag1     = op_tag[0];
    assign rs_tag2     = op_tag[1];
    assign rs_ready1   = op_ready[0];
    assign rs_ready2   = op_ready[1];
    assign rs_dest_tag = rob_alloc_tag;

    ////////////////////////////////////////////////////////////////////////////
    // register file and map table update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            regfile  <= '{default: '0};
            map_busy <= '0;
            map_tag  <= '{default: '0};
        end else begin
            if (retire_valid && (retire_dest != '0)) begin
                regfile[retire_dest] <= retire_value;
                // a younger writer may already own the register
                if (map_busy[retire_dest] && (map_tag[retire_dest] == retire_tag)) begin
                    map_busy[retire_dest] <= 1'b0;
                end
            end
            // new mapping wins over a retire to the same register
            if (fire && (inst_dest != '0)) begin
                map_busy[inst_dest] <= 1'b1;
                map_tag[inst_dest]  <= rob_alloc_tag;
            end
        end
    end

endmodule

//--- logic/ooo_pkg.sv
// out-of-order core shared definitions
// data and register widths, ALU operations and operand-b source

package ooo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // one data word
    typedef logic [31:0] xlen_t;

    // architectural register index, r0 is hardwired to zero
    typedef logic [4:0] reg_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // shifts take the low 5 bits of operand b
    // mul keeps the low word of the product
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_MUL = 3'd7
    } alu_func_e;

    // operand b from the second source register or the immediate
    typedef enum logic {
        OPB_IS_RS2 = 1'b0,
        OPB_IS_IMM = 1'b1
    } opb_select_e;

endpackage
